// File: rtl/bp_kind_pkg.sv
`default_nettype none

package bp_kind_pkg;

    localparam int KIND_WIDTH = 3;

    localparam logic [KIND_WIDTH-1:0] NOT_JUMP      = 3'd0;
    localparam logic [KIND_WIDTH-1:0] DIRECT_JUMP   = 3'd1;
    localparam logic [KIND_WIDTH-1:0] RET           = 3'd4;
    localparam logic [KIND_WIDTH-1:0] INDIRECT_JUMP = 3'd5;
    localparam logic [KIND_WIDTH-1:0] CALL          = 3'd6;
    localparam logic [KIND_WIDTH-1:0] JUMP          = 3'd7;

    // bit 2 marks unconditional transfers, bit 0 defers to the direction tables
    function automatic logic kind_taken(input logic [KIND_WIDTH-1:0] kind, input logic dir);
        return kind[2] | (kind[0] & dir);
    endfunction

    function automatic logic is_conditional(input logic [KIND_WIDTH-1:0] kind);
        return kind == DIRECT_JUMP;
    endfunction

endpackage

`default_nettype wire

// File: rtl/bp_cfg_pkg.sv
`default_nettype none

package bp_cfg_pkg;

    localparam int PC_WIDTH       = 30;
    localparam int BH_WIDTH       = 16;
    localparam int GH_WIDTH       = 32;
    localparam int INDEX_WIDTH    = 6;
    localparam int TABLE_SIZE     = 1 << INDEX_WIDTH;
    localparam int QUEUE_DEPTH    = 4;
    localparam int QPTR_WIDTH     = $clog2(QUEUE_DEPTH);
    localparam int QCNT_WIDTH     = QPTR_WIDTH + 1;
    localparam int MISS_CNT_WIDTH = 16;

    typedef logic [1:0] ctr_t;

    // weakly not taken, or weakly local for the chooser
    localparam ctr_t CTR_RESET = 2'd1;

    typedef struct packed {
        logic [INDEX_WIDTH-1:0] local_idx;
        logic [INDEX_WIDTH-1:0] gshare_idx;
        logic [INDEX_WIDTH-1:0] chooser_idx;
        ctr_t                   local_ctr;
        ctr_t                   gshare_ctr;
        ctr_t                   chooser_ctr;
        logic                   pred_dir;
        logic [2:0]             spare;
    } pred_meta_t;

    function automatic ctr_t ctr_next(input ctr_t ctr, input logic taken);
        if (taken) begin
            return (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    endfunction

endpackage

`default_nettype wire

// File: rtl/bp_update_if.sv
`default_nettype none

interface bp_update_if;
    import bp_cfg_pkg::*;

    logic                   upd_en;
    logic [INDEX_WIDTH-1:0] local_idx;
    ctr_t                   local_ctr;
    logic [INDEX_WIDTH-1:0] gshare_idx;
    ctr_t                   gshare_ctr;
    logic                   chooser_en;
    logic [INDEX_WIDTH-1:0] chooser_idx;
    ctr_t                   chooser_ctr;

    modport src (
        output upd_en, local_idx, local_ctr, gshare_idx, gshare_ctr,
               chooser_en, chooser_idx, chooser_ctr
    );

    modport dst (
        input upd_en, local_idx, local_ctr, gshare_idx, gshare_ctr,
              chooser_en, chooser_idx, chooser_ctr
    );

endinterface

`default_nettype wire

// File: rtl/counter_pht.sv
`default_nettype none

module counter_pht (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire  [bp_cfg_pkg::INDEX_WIDTH-1:0]     rd_idx,
    output bp_cfg_pkg::ctr_t                       rd_ctr,
    input  wire                                    wr_en,
    input  wire  [bp_cfg_pkg::INDEX_WIDTH-1:0]     wr_idx,
    input  wire  bp_cfg_pkg::ctr_t                 wr_ctr
);
    import bp_cfg_pkg::*;

    ctr_t table_q [TABLE_SIZE];

    // whole table returns to the weak state on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                table_q[i] <= CTR_RESET;
            end
        end else if (wr_en) begin
            table_q[wr_idx] <= wr_ctr;
        end
    end

    // read sees the pre-write value when indexes collide
    assign rd_ctr = table_q[rd_idx];

endmodule

`default_nettype wire

// File: rtl/dir_predictor.sv
`default_nettype none

module dir_predictor (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   stall,
    input  wire                                   req_valid,
    input  wire  [bp_cfg_pkg::PC_WIDTH-1:0]       req_pc,
    input  wire  [bp_cfg_pkg::BH_WIDTH-1:0]       req_bh,
    input  wire  [bp_cfg_pkg::GH_WIDTH-1:0]       req_gh,
    input  wire  [bp_kind_pkg::KIND_WIDTH-1:0]    req_kind,
    input  wire                                   q_full,
    output logic                                  push,
    output bp_cfg_pkg::pred_meta_t                meta,
    bp_update_if.dst                              upd,
    output logic                                  pred_valid,
    output logic                                  pred_taken,
    output logic                                  pred_choice
);
    import bp_cfg_pkg::*;
    import bp_kind_pkg::*;

    logic [INDEX_WIDTH-1:0] local_idx;
    logic [INDEX_WIDTH-1:0] gshare_idx;
    logic [INDEX_WIDTH-1:0] chooser_idx;
    ctr_t                   local_ctr;
    ctr_t                   gshare_ctr;
    ctr_t                   chooser_ctr;
    logic                   use_gshare;
    logic                   chosen_dir;
    logic                   accept;
    logic                   cond;

    assign local_idx   = req_pc[INDEX_WIDTH-1:0] ^ req_bh[INDEX_WIDTH-1:0];
    assign gshare_idx  = req_pc[INDEX_WIDTH-1:0] ^ req_gh[INDEX_WIDTH-1:0];
    assign chooser_idx = req_pc[INDEX_WIDTH-1:0];

    counter_pht local_pht (
        .clk    (clk),
        .reset  (reset),
        .rd_idx (local_idx),
        .rd_ctr (local_ctr),
        .wr_en  (upd.upd_en),
        .wr_idx (upd.local_idx),
        .wr_ctr (upd.local_ctr)
    );

    counter_pht gshare_pht (
        .clk    (clk),
        .reset  (reset),
        .rd_idx (gshare_idx),
        .rd_ctr (gshare_ctr),
        .wr_en  (upd.upd_en),
        .wr_idx (upd.gshare_idx),
        .wr_ctr (upd.gshare_ctr)
    );

    counter_pht chooser_pht (
        .clk    (clk),
        .reset  (reset),
        .rd_idx (chooser_idx),
        .rd_ctr (chooser_ctr),
        .wr_en  (upd.chooser_en),
        .wr_idx (upd.chooser_idx),
        .wr_ctr (upd.chooser_ctr)
    );

    // msb of a counter is its taken / gshare vote
    assign use_gshare = chooser_ctr[1];
    assign chosen_dir = use_gshare ? gshare_ctr[1] : local_ctr[1];

    assign accept = req_valid & ~stall & ~q_full;
    assign cond   = is_conditional(req_kind);
    assign push   = accept & cond;

    // snapshot of everything the resolve needs later
    assign meta.local_idx   = local_idx;
    assign meta.gshare_idx  = gshare_idx;
    assign meta.chooser_idx = chooser_idx;
    assign meta.local_ctr   = local_ctr;
    assign meta.gshare_ctr  = gshare_ctr;
    assign meta.chooser_ctr = chooser_ctr;
    assign meta.pred_dir    = chosen_dir;
    assign meta.spare       = 3'b000;

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_valid  <= 1'b0;
            pred_taken  <= 1'b0;
            pred_choice <= 1'b0;
        end else begin
            pred_valid  <= accept;
            pred_taken  <= accept & kind_taken(req_kind, chosen_dir);
            pred_choice <= push & use_gshare;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pdc_queue.sv
`default_nettype none

module pdc_queue (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           push,
    input  wire  bp_cfg_pkg::pred_meta_t  meta,
    input  wire                           pop,
    output bp_cfg_pkg::pred_meta_t        head,
    output logic                          empty,
    output logic                          full
);
    import bp_cfg_pkg::*;

    pred_meta_t             mem_q [QUEUE_DEPTH];
    logic [QPTR_WIDTH-1:0]  wr_ptr;
    logic [QPTR_WIDTH-1:0]  rd_ptr;
    logic [QCNT_WIDTH-1:0]  count;
    logic                   do_push;
    logic                   do_pop;

    function automatic logic [QPTR_WIDTH-1:0] ptr_inc(input logic [QPTR_WIDTH-1:0] ptr);
        return (ptr == QPTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == QCNT_WIDTH'(QUEUE_DEPTH));

    // a pop frees the slot a same-cycle push needs
    assign do_pop  = pop & ~empty;
    assign do_push = push & (~full | do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr] <= meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = mem_q[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/resolve_unit.sv
`default_nettype none

module resolve_unit (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire                                      res_valid,
    input  wire                                      res_taken,
    input  wire  bp_cfg_pkg::pred_meta_t             head,
    input  wire                                      empty,
    output logic                                     pop,
    bp_update_if.src                                 upd,
    output logic                                     res_mispredict,
    output logic                                     res_error,
    output logic [bp_cfg_pkg::MISS_CNT_WIDTH-1:0]    mispredict_count
);
    import bp_cfg_pkg::*;

    logic take;
    logic local_dir;
    logic gshare_dir;
    logic mispredict;

    assign take       = res_valid & ~empty;
    assign pop        = take;
    assign local_dir  = head.local_ctr[1];
    assign gshare_dir = head.gshare_ctr[1];
    assign mispredict = head.pred_dir != res_taken;

    // write back from the stored snapshot, not a fresh table read
    assign upd.upd_en     = take;
    assign upd.local_idx  = head.local_idx;
    assign upd.local_ctr  = ctr_next(head.local_ctr, res_taken);
    assign upd.gshare_idx = head.gshare_idx;
    assign upd.gshare_ctr = ctr_next(head.gshare_ctr, res_taken);

    // only train the chooser when the two tables disagreed
    // counting up favours gshare
    assign upd.chooser_en  = take & (local_dir != gshare_dir);
    assign upd.chooser_idx = head.chooser_idx;
    assign upd.chooser_ctr = ctr_next(head.chooser_ctr, gshare_dir == res_taken);

    always_ff @(posedge clk) begin
        if (reset) begin
            res_mispredict   <= 1'b0;
            res_error        <= 1'b0;
            mispredict_count <= '0;
        end else begin
            res_mispredict <= take & mispredict;
            res_error      <= res_valid & empty;
            // saturates at all ones
            if (take && mispredict && mispredict_count != '1) begin
                mispredict_count <= mispredict_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/bp_top.sv
`default_nettype none

module bp_top (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire                                      stall,
    input  wire                                      req_valid,
    input  wire  [bp_cfg_pkg::PC_WIDTH-1:0]          req_pc,
    input  wire  [bp_cfg_pkg::BH_WIDTH-1:0]          req_bh,
    input  wire  [bp_cfg_pkg::GH_WIDTH-1:0]          req_gh,
    input  wire  [bp_kind_pkg::KIND_WIDTH-1:0]       req_kind,
    output logic                                     req_ready,
    input  wire                                      res_valid,
    input  wire                                      res_taken,
    output logic                                     pred_valid,
    output logic                                     pred_taken,
    output logic                                     pred_choice,
    output logic                                     res_mispredict,
    output logic                                     res_error,
    output logic [bp_cfg_pkg::MISS_CNT_WIDTH-1:0]    mispredict_count
);
    import bp_cfg_pkg::*;

    logic       q_push;
    logic       q_pop;
    logic       q_full;
    logic       q_empty;
    pred_meta_t push_meta;
    pred_meta_t head_meta;

    bp_update_if upd_bus ();

    assign req_ready = ~q_full;

    dir_predictor u_predictor (
        .clk(clk), .reset(reset), .stall(stall), .req_valid(req_valid),
        .req_pc(req_pc), .req_bh(req_bh), .req_gh(req_gh), .req_kind(req_kind),
        .q_full(q_full), .push(q_push), .meta(push_meta), .upd(upd_bus),
        .pred_valid(pred_valid), .pred_taken(pred_taken), .pred_choice(pred_choice)
    );

    pdc_queue u_queue (
        .clk(clk), .reset(reset), .push(q_push), .meta(push_meta),
        .pop(q_pop), .head(head_meta), .empty(q_empty), .full(q_full)
    );

    resolve_unit u_resolve (
        .clk(clk), .reset(reset), .res_valid(res_valid), .res_taken(res_taken),
        .head(head_meta), .empty(q_empty), .pop(q_pop), .upd(upd_bus),
        .res_mispredict(res_mispredict), .res_error(res_error),
        .mispredict_count(mispredict_count)
    );

endmodule

`default_nettype wire

// File: bench/bp_clkgen.sv
`default_nettype none

module bp_clkgen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // held over four rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/bp_checker.sv
`default_nettype none

module bp_checker (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   stall,
    input  wire                                   req_valid,
    input  wire  [bp_cfg_pkg::PC_WIDTH-1:0]       req_pc,
    input  wire  [bp_cfg_pkg::BH_WIDTH-1:0]       req_bh,
    input  wire  [bp_cfg_pkg::GH_WIDTH-1:0]       req_gh,
    input  wire  [bp_kind_pkg::KIND_WIDTH-1:0]    req_kind,
    input  wire                                   req_ready,
    input  wire                                   res_valid,
    input  wire                                   res_taken,
    input  wire                                   pred_valid,
    input  wire                                   pred_taken,
    input  wire                                   pred_choice,
    input  wire                                   res_mispredict,
    input  wire                                   res_error,
    input  wire  [15:0]                           mispredict_count,
    output int                                    error_count,
    output int                                    check_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import bp_cfg_pkg::*;
    import bp_kind_pkg::*;

    typedef struct packed {
        logic [5:0] li;
        logic [5:0] gi;
        logic [5:0] ci;
        logic [1:0] lc;
        logic [1:0] gc;
        logic [1:0] cc;
        logic       dir;
    } snap_t;

    logic [1:0]  local_tab [TABLE_SIZE];
    logic [1:0]  gshare_tab [TABLE_SIZE];
    logic [1:0]  chooser_tab [TABLE_SIZE];
    snap_t       pending [$];
    logic        exp_valid;
    logic        exp_taken;
    logic        exp_choice;
    logic        exp_mis;
    logic        exp_err;
    logic [15:0] exp_count;
    logic        armed;

    // clamp to the 0..3 counter range
    function automatic logic [1:0] saturate_step(input logic [1:0] c, input logic up);
        int v;
        v = up ? int'(c) + 1 : int'(c) - 1;
        if (v > 3) begin
            v = 3;
        end
        if (v < 0) begin
            v = 0;
        end
        return v[1:0];
    endfunction

    function automatic logic kind_outcome(input logic [2:0] kind, input logic dir);
        case (kind)
            RET, INDIRECT_JUMP, CALL, JUMP: return 1'b1;
            DIRECT_JUMP:                    return dir;
            default:                        return 1'b0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("ERROR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        armed = 1'b0;
    end

    // reference model steps on the rising edge
    always @(posedge clk) begin : model
        logic [5:0] li;
        logic [5:0] gi;
        logic [5:0] ci;
        logic [1:0] lc;
        logic [1:0] gc;
        logic [1:0] cc;
        logic       use_g;
        logic       dir;
        logic       accept;
        logic       cond;
        logic       take;
        snap_t      h;
        armed = 1'b1;
        if (reset) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                local_tab[i] = CTR_RESET;
                gshare_tab[i] = CTR_RESET;
                chooser_tab[i] = CTR_RESET;
            end
            pending.delete();
            {exp_valid, exp_taken, exp_choice, exp_mis, exp_err} = '0;
            exp_count = '0;
        end else begin
            li = req_pc[5:0] ^ req_bh[5:0];
            gi = req_pc[5:0] ^ req_gh[5:0];
            ci = req_pc[5:0];
            // tables read before this edge's write-back
            lc = local_tab[li];
            gc = gshare_tab[gi];
            cc = chooser_tab[ci];
            use_g = (cc >= 2'd2);
            dir = use_g ? (gc >= 2'd2) : (lc >= 2'd2);
            accept = req_valid && !stall && pending.size() < QUEUE_DEPTH;
            cond = (req_kind == DIRECT_JUMP);
            exp_valid = accept;
            exp_taken = accept && kind_outcome(req_kind, dir);
            exp_choice = accept && cond && use_g;
            take = res_valid && pending.size() > 0;
            exp_err = res_valid && pending.size() == 0;
            exp_mis = 1'b0;
            if (take) begin
                h = pending.pop_front();
                local_tab[h.li] = saturate_step(h.lc, res_taken);
                gshare_tab[h.gi] = saturate_step(h.gc, res_taken);
                if ((h.lc >= 2'd2) != (h.gc >= 2'd2)) begin
                    chooser_tab[h.ci] = saturate_step(h.cc, (h.gc >= 2'd2) == res_taken);
                end
                exp_mis = (h.dir != res_taken);
                if (exp_mis && exp_count != 16'hffff) begin
                    exp_count++;
                end
            end
            if (accept && cond) begin
                pending.push_back({li, gi, ci, lc, gc, cc, dir});
            end
        end
    end

    always @(negedge clk) begin
        if (armed) begin
            compare("pred_valid", exp_valid, pred_valid);
            compare("pred_taken", exp_taken, pred_taken);
            compare("pred_choice", exp_choice, pred_choice);
            compare("res_mispredict", exp_mis, res_mispredict);
            compare("res_error", exp_err, res_error);
            compare("mispredict_count", exp_count, mispredict_count);
            compare("req_ready", pending.size() < QUEUE_DEPTH, req_ready);
        end
    end

endmodule

`default_nettype wire

// File: bench/bp_tb.sv
`default_nettype none

module bp_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import bp_cfg_pkg::*;
    import bp_kind_pkg::*;

    logic                    clk;
    logic                    reset;
    logic                    stall;
    logic                    req_valid;
    logic [PC_WIDTH-1:0]     req_pc;
    logic [BH_WIDTH-1:0]     req_bh;
    logic [GH_WIDTH-1:0]     req_gh;
    logic [KIND_WIDTH-1:0]   req_kind;
    logic                    req_ready;
    logic                    res_valid;
    logic                    res_taken;
    logic                    pred_valid;
    logic                    pred_taken;
    logic                    pred_choice;
    logic                    res_mispredict;
    logic                    res_error;
    logic [15:0]             mispredict_count;
    int                      error_count;
    int                      check_count;
    int                      timeout_count;
    int                      seed;
    int                      ptr;
    logic [31:0]             vec [256];

    bp_clkgen clkgen0 (.clk(clk), .reset(reset));

    bp_top dut0 (
        .clk(clk), .reset(reset), .stall(stall), .req_valid(req_valid),
        .req_pc(req_pc), .req_bh(req_bh), .req_gh(req_gh), .req_kind(req_kind),
        .req_ready(req_ready), .res_valid(res_valid), .res_taken(res_taken),
        .pred_valid(pred_valid), .pred_taken(pred_taken), .pred_choice(pred_choice),
        .res_mispredict(res_mispredict), .res_error(res_error),
        .mispredict_count(mispredict_count)
    );

    bp_checker checker0 (
        .clk(clk), .reset(reset), .stall(stall), .req_valid(req_valid),
        .req_pc(req_pc), .req_bh(req_bh), .req_gh(req_gh), .req_kind(req_kind),
        .req_ready(req_ready), .res_valid(res_valid), .res_taken(res_taken),
        .pred_valid(pred_valid), .pred_taken(pred_taken), .pred_choice(pred_choice),
        .res_mispredict(res_mispredict), .res_error(res_error),
        .mispredict_count(mispredict_count),
        .error_count(error_count), .check_count(check_count)
    );

    // each record takes six words of the vector file
    task automatic drive_record(input int base);
        req_valid = (vec[base] == 32'd1);
        res_valid = (vec[base] == 32'd2);
        stall = 1'b0;
        if (vec[base] == 32'd1) begin
            req_pc = vec[base+1][PC_WIDTH-1:0];
            req_bh = vec[base+2][BH_WIDTH-1:0];
            req_gh = vec[base+3];
            req_kind = vec[base+4][KIND_WIDTH-1:0];
            stall = vec[base+5][0];
        end
        if (vec[base] == 32'd2) begin
            res_taken = vec[base+5][0];
        end
    endtask

    // small pc and history ranges so indexes collide often
    task automatic draw_random();
        logic [31:0] r;
        r = $random(seed);
        req_valid = r[0] | r[1];
        req_pc = PC_WIDTH'(r[9:6]);
        req_bh = BH_WIDTH'(r[13:10]);
        req_gh = GH_WIDTH'(r[17:14]);
        case (r[20:18])
            3'd3:    req_kind = NOT_JUMP;
            3'd4:    req_kind = RET;
            3'd5:    req_kind = INDIRECT_JUMP;
            3'd6:    req_kind = CALL;
            3'd7:    req_kind = JUMP;
            default: req_kind = DIRECT_JUMP;
        endcase
        stall = (r[23:21] == 3'd0);
        // resolves about as often as pushes so several snapshots stay queued
        res_valid = r[24] & r[25];
        res_taken = r[26];
    endtask

    initial begin
        int n;
        seed = 32'h116a_170e;
        timeout_count = 0;
        stall = 1'b0;
        req_valid = 1'b0;
        req_pc = '0;
        req_bh = '0;
        req_gh = '0;
        req_kind = NOT_JUMP;
        res_valid = 1'b0;
        res_taken = 1'b0;
        $readmemh("bench/bp_vectors.txt", vec);
        n = 0;
        while (reset !== 1'b0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (reset !== 1'b0) begin
            $display("reset was never released");
            timeout_count++;
        end
        @(negedge clk);
        ptr = 0;
        while (ptr + 5 < $size(vec) && vec[ptr] < 32'd4) begin
            if (vec[ptr] == 32'd3) begin
                for (int i = 0; i < vec[ptr+5]; i++) begin
                    draw_random();
                    @(negedge clk);
                end
            end else begin
                drive_record(ptr);
                @(negedge clk);
            end
            ptr += 6;
        end
        req_valid = 1'b0;
        res_valid = 1'b0;
        stall = 1'b0;
        n = 0;
        @(negedge clk);
        while ((pred_valid || res_mispredict || res_error) && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (pred_valid || res_mispredict || res_error) begin
            $display("outputs did not go idle after the last record");
            timeout_count++;
        end
        @(posedge clk);
        $display("errors %0d timeouts %0d checks %0d", error_count, timeout_count, check_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/bp_vectors.txt
// columns: op pc bh gh kind arg
// op 0 idle, 1 request (arg stall), 2 resolve (arg taken), 3 random (arg cycles)
1 00000100 0000 00000000 4 0
1 00000101 0000 00000000 5 0
1 00000102 0000 00000000 6 0
1 00000103 0000 00000000 7 0
1 00000104 0000 00000000 0 0
1 00000040 0000 00000000 1 0
2 00000000 0000 00000000 0 0
// training one conditional pc
1 00000010 0000 00000000 1 0
2 00000000 0000 00000000 0 1
1 00000010 0000 00000000 1 0
2 00000000 0000 00000000 0 1
1 00000010 0000 00000000 1 0
2 00000000 0000 00000000 0 1
0 00000000 0000 00000000 0 0
// same pc, gh selects the outcome
1 00000020 0000 00000001 1 0
2 00000000 0000 00000000 0 1
1 00000020 0000 00000002 1 0
2 00000000 0000 00000000 0 0
1 00000020 0000 00000001 1 0
2 00000000 0000 00000000 0 1
// fill the queue, fifth request dropped
1 00000030 0000 00000000 1 0
1 00000030 0000 00000000 1 0
1 00000030 0000 00000000 1 0
1 00000030 0000 00000000 1 0
1 00000030 0000 00000000 1 0
2 00000000 0000 00000000 0 1
2 00000000 0000 00000000 0 0
2 00000000 0000 00000000 0 1
2 00000000 0000 00000000 0 0
// stalled request, then resolve on an empty queue
1 00000030 0000 00000000 1 1
2 00000000 0000 00000000 0 1
0 00000000 0000 00000000 0 0
3 00000000 0000 00000000 0 c8

// File: build.f
rtl/bp_kind_pkg.sv
rtl/bp_cfg_pkg.sv
rtl/bp_update_if.sv
rtl/counter_pht.sv
rtl/dir_predictor.sv
rtl/pdc_queue.sv
rtl/resolve_unit.sv
rtl/bp_top.sv
bench/bp_clkgen.sv
bench/bp_checker.sv
bench/bp_tb.sv
